// File: include/rob_cfg.svh
// reorder buffer configuration: depth, word widths and instruction size
`ifndef ROB_CFG_SVH
`define ROB_CFG_SVH

// index bits into the entry array
`define ROB_WIDTH 3

// entry count, also the reserved no-dependency query index
`define ROB_SIZE (1 << `ROB_WIDTH)

// data and pc word width
`define XLEN 32

// architectural register number width
`define REG_WIDTH 5

// dispatcher opcode code width
`define OPCODE_WIDTH 7

// byte step from pc to the sequential next pc
`define INSN_BYTES 4

`endif

// File: src/rob_pkg.sv
// reorder buffer types: dispatcher opcodes, entry op types and the result word
`include "rob_cfg.svh"

package rob_pkg;

    // opcode codes as already decoded by the dispatcher
    typedef enum logic [`OPCODE_WIDTH-1:0] {
        op_lui = 7'd1,
        op_auipc = 7'd2,
        op_jal = 7'd3,
        op_jalr = 7'd4,
        // branches
        op_beq = 7'd5, op_bne = 7'd6, op_blt = 7'd7,
        op_bge = 7'd8, op_bltu = 7'd9, op_bgeu = 7'd10,
        // loads
        op_lb = 7'd11, op_lh = 7'd12, op_lw = 7'd13,
        op_lbu = 7'd14, op_lhu = 7'd15,
        // stores
        op_sb = 7'd16, op_sh = 7'd17, op_sw = 7'd18,
        // immediate alu
        op_addi = 7'd19, op_slti = 7'd20, op_sltiu = 7'd21,
        op_xori = 7'd22, op_ori = 7'd23, op_andi = 7'd24,
        op_slli = 7'd25, op_srli = 7'd26, op_srai = 7'd27,
        // register alu
        op_add = 7'd28, op_sub = 7'd29, op_sll = 7'd30,
        op_slt = 7'd31, op_sltu = 7'd32, op_xorr = 7'd33,
        op_srl = 7'd34, op_sra = 7'd35, op_orr = 7'd36,
        op_andr = 7'd37
    } opcode_t;

    // what commit has to do with an entry
    typedef enum logic [2:0] {
        type_empty = 3'd0,
        type_register = 3'd1,
        type_branch = 3'd2,
        type_jalr = 3'd3,
        type_store = 3'd4
    } op_type_t;

    // result word, read whole or as the branch outcome
    typedef union packed {
        logic [`XLEN-1:0] value;
        struct packed {
            logic [`XLEN-2:0] pad;
            logic taken;
        } branch;
    } rob_result_u;

endpackage

// File: src/rob_op_classify.sv
// opcode classifier: sorts dispatcher opcodes into reorder buffer op types
`include "rob_cfg.svh"

module rob_op_classify (
    input  rob_pkg::opcode_t  opcode,
    output rob_pkg::op_type_t op_type
);

    always_comb begin
        case (opcode)
            // jal already folded into a plain register write
            rob_pkg::op_lui, rob_pkg::op_auipc, rob_pkg::op_jal,
            rob_pkg::op_lb, rob_pkg::op_lh, rob_pkg::op_lw,
            rob_pkg::op_lbu, rob_pkg::op_lhu,
            rob_pkg::op_addi, rob_pkg::op_slti, rob_pkg::op_sltiu,
            rob_pkg::op_xori, rob_pkg::op_ori, rob_pkg::op_andi,
            rob_pkg::op_slli, rob_pkg::op_srli, rob_pkg::op_srai,
            rob_pkg::op_add, rob_pkg::op_sub, rob_pkg::op_sll,
            rob_pkg::op_slt, rob_pkg::op_sltu, rob_pkg::op_xorr,
            rob_pkg::op_srl, rob_pkg::op_sra, rob_pkg::op_orr,
            rob_pkg::op_andr:
                op_type = rob_pkg::type_register;
            rob_pkg::op_beq, rob_pkg::op_bne, rob_pkg::op_blt,
            rob_pkg::op_bge, rob_pkg::op_bltu, rob_pkg::op_bgeu:
                op_type = rob_pkg::type_branch;
            // rd gets pc+4, target fed back to fetch
            rob_pkg::op_jalr:
                op_type = rob_pkg::type_jalr;
            // memory write is done by the load/store buffer
            rob_pkg::op_sb, rob_pkg::op_sh, rob_pkg::op_sw:
                op_type = rob_pkg::type_store;
            default:
                op_type = rob_pkg::type_empty;
        endcase
    end

    // every defined code must land in a real class
    always_comb begin
        if (opcode >= rob_pkg::op_lui && opcode <= rob_pkg::op_andr) begin
            assert (op_type != rob_pkg::type_empty);
        end
    end

endmodule

// File: src/rob_entry_file.sv
// reorder buffer entry file: storage, pointers, allocation, completion and queries
`include "rob_cfg.svh"

module rob_entry_file (
    input  logic                    clk_in,
    input  logic                    rst_in,
    input  logic                    rdy_in,
    input  logic                    alloc_en,
    input  rob_pkg::op_type_t       alloc_op_type,
    input  logic [`REG_WIDTH-1:0]   alloc_rd,
    input  logic [`XLEN-1:0]        alloc_pc,
    input  logic [`XLEN-1:0]        alloc_next_pc,
    input  logic                    alloc_predict_taken,
    input  logic                    alloc_ready,
    input  logic [`XLEN-1:0]        alloc_data,
    input  logic                    cdb_rs_en,
    input  logic [`ROB_WIDTH-1:0]   cdb_rs_index,
    input  logic [`XLEN-1:0]        cdb_rs_data,
    input  logic                    cdb_lsb_en,
    input  logic [`ROB_WIDTH-1:0]   cdb_lsb_index,
    input  logic [`XLEN-1:0]        cdb_lsb_data,
    input  logic [`ROB_WIDTH:0]     query_j_index,
    input  logic [`ROB_WIDTH:0]     query_k_index,
    input  logic                    retire_en,
    input  logic                    flush_clear,
    output logic                    query_j_ready,
    output logic [`XLEN-1:0]        query_j_data,
    output logic                    query_k_ready,
    output logic [`XLEN-1:0]        query_k_data,
    output logic                    head_ready,
    output rob_pkg::op_type_t       head_op_type,
    output logic [`REG_WIDTH-1:0]   head_rd,
    output logic [`XLEN-1:0]        head_pc,
    output logic [`XLEN-1:0]        head_next_pc,
    output logic                    head_predict_taken,
    output rob_pkg::rob_result_u    head_result,
    output logic [`ROB_WIDTH-1:0]   head_index,
    output logic [`ROB_WIDTH-1:0]   tail_index,
    output logic                    full
);

    // per-entry state
    logic                 busy [`ROB_SIZE];
    logic                 ready [`ROB_SIZE];
    rob_pkg::op_type_t    op_type [`ROB_SIZE];
    logic [`REG_WIDTH-1:0] rd [`ROB_SIZE];
    logic [`XLEN-1:0]     pc [`ROB_SIZE];
    logic [`XLEN-1:0]     next_pc [`ROB_SIZE];
    logic                 predict_taken [`ROB_SIZE];
    rob_pkg::rob_result_u result [`ROB_SIZE];

    logic [`ROB_WIDTH-1:0] head_ptr;
    logic [`ROB_WIDTH-1:0] tail_ptr;
    logic                  alloc_fire;

    // full when the pointers meet on an occupied slot
    assign full = busy[head_ptr] && (head_ptr == tail_ptr);
    assign alloc_fire = alloc_en && !full && rdy_in && !flush_clear;

    assign head_index = head_ptr;
    assign tail_index = tail_ptr;
    assign head_ready = busy[head_ptr] && ready[head_ptr];
    assign head_op_type = op_type[head_ptr];
    assign head_rd = rd[head_ptr];
    assign head_pc = pc[head_ptr];
    assign head_next_pc = next_pc[head_ptr];
    assign head_predict_taken = predict_taken[head_ptr];
    assign head_result = result[head_ptr];

    // top index bit set means no dependency
    assign query_j_ready = !query_j_index[`ROB_WIDTH] && ready[query_j_index[`ROB_WIDTH-1:0]];
    assign query_j_data = query_j_index[`ROB_WIDTH] ? '0 : result[query_j_index[`ROB_WIDTH-1:0]].value;
    assign query_k_ready = !query_k_index[`ROB_WIDTH] && ready[query_k_index[`ROB_WIDTH-1:0]];
    assign query_k_data = query_k_index[`ROB_WIDTH] ? '0 : result[query_k_index[`ROB_WIDTH-1:0]].value;

    // control: pointers wrap at ROB_SIZE by index overflow
    always_ff @(posedge clk_in) begin
        if (rst_in || (rdy_in && flush_clear)) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            for (int i = 0; i < `ROB_SIZE; i++) begin
                busy[i] <= 1'b0;
                ready[i] <= 1'b0;
            end
        end else if (rdy_in) begin
            if (alloc_fire) begin
                busy[tail_ptr] <= 1'b1;
                ready[tail_ptr] <= alloc_ready;
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (cdb_rs_en) begin
                ready[cdb_rs_index] <= 1'b1;
            end
            // lsb after rs
            if (cdb_lsb_en) begin
                ready[cdb_lsb_index] <= 1'b1;
            end
            if (retire_en) begin
                busy[head_ptr] <= 1'b0;
                ready[head_ptr] <= 1'b0;
                head_ptr <= head_ptr + 1'b1;
            end
        end
    end

    // payload, same write order as the flags
    always_ff @(posedge clk_in) begin
        if (alloc_fire) begin
            op_type[tail_ptr] <= alloc_op_type;
            rd[tail_ptr] <= alloc_rd;
            pc[tail_ptr] <= alloc_pc;
            next_pc[tail_ptr] <= alloc_next_pc;
            predict_taken[tail_ptr] <= alloc_predict_taken;
            result[tail_ptr].value <= alloc_ready ? alloc_data : '0;
        end
        if (rdy_in && cdb_rs_en) begin
            result[cdb_rs_index].value <= cdb_rs_data;
        end
        if (rdy_in && cdb_lsb_en) begin
            result[cdb_lsb_index].value <= cdb_lsb_data;
        end
    end

    // completions only for live entries
    a_cdb_rs_busy: assert property (@(posedge clk_in) disable iff (rst_in)
        cdb_rs_en && rdy_in && !flush_clear |-> busy[cdb_rs_index]);
    a_cdb_lsb_busy: assert property (@(posedge clk_in) disable iff (rst_in)
        cdb_lsb_en && rdy_in && !flush_clear |-> busy[cdb_lsb_index]);
    // commit never retires an unfinished head
    a_retire_ready: assert property (@(posedge clk_in) disable iff (rst_in)
        retire_en |-> head_ready);

endmodule

// File: src/rob_commit.sv
// reorder buffer commit unit: in-order retirement pulses and the mispredict flush
`include "rob_cfg.svh"

module rob_commit (
    input  logic                    clk_in,
    input  logic                    rst_in,
    input  logic                    rdy_in,
    input  logic                    head_ready,
    input  rob_pkg::op_type_t       head_op_type,
    input  logic [`REG_WIDTH-1:0]   head_rd,
    input  logic [`XLEN-1:0]        head_pc,
    input  logic [`XLEN-1:0]        head_next_pc,
    input  logic                    head_predict_taken,
    input  rob_pkg::rob_result_u    head_result,
    input  logic [`ROB_WIDTH-1:0]   head_index,
    output logic                    retire_en,
    output logic                    flush_clear,
    output logic                    rf_update_en,
    output logic [`REG_WIDTH-1:0]   rf_update_reg,
    output logic [`ROB_WIDTH-1:0]   rf_update_index,
    output logic [`XLEN-1:0]        rf_update_data,
    output logic                    jalr_feedback_en,
    output logic [`XLEN-1:0]        jalr_feedback_target,
    output logic [`XLEN-1:0]        correct_next_pc,
    output logic                    bp_update_en,
    output logic [`XLEN-1:0]        bp_update_pc,
    output logic                    bp_update_taken,
    output logic                    flush_signal
);

    logic             flush_second;
    logic [`XLEN-1:0] seq_pc;
    logic             mispredict;

    assign seq_pc = head_pc + `INSN_BYTES;
    assign mispredict = head_result.branch.taken != head_predict_taken;

    // nothing retires while flushing or stalled
    assign retire_en = head_ready && !flush_signal && rdy_in;
    // entries cleared only in the first flush cycle
    assign flush_clear = flush_signal && !flush_second;

    // pulses and flush sequencer
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            rf_update_en <= 1'b0;
            jalr_feedback_en <= 1'b0;
            bp_update_en <= 1'b0;
            flush_signal <= 1'b0;
            flush_second <= 1'b0;
        end else if (rdy_in) begin
            rf_update_en <= 1'b0;
            jalr_feedback_en <= 1'b0;
            bp_update_en <= 1'b0;
            if (flush_signal) begin
                // clear cycle, then one idle cycle
                flush_second <= !flush_second;
                if (flush_second) begin
                    flush_signal <= 1'b0;
                end
            end else if (retire_en) begin
                case (head_op_type)
                    rob_pkg::type_register: rf_update_en <= 1'b1;
                    rob_pkg::type_jalr: begin
                        rf_update_en <= 1'b1;
                        jalr_feedback_en <= 1'b1;
                    end
                    rob_pkg::type_branch: begin
                        bp_update_en <= 1'b1;
                        flush_signal <= mispredict;
                    end
                    // stores retire silently
                    default: ;
                endcase
            end
        end
    end

    // commit payload, only sampled on a retiring edge
    always_ff @(posedge clk_in) begin
        if (retire_en) begin
            rf_update_reg <= head_rd;
            rf_update_index <= head_index;
            // jalr links pc+4, others write their result
            rf_update_data <= (head_op_type == rob_pkg::type_jalr) ? seq_pc : head_result.value;
            jalr_feedback_target <= head_result.value;
            bp_update_pc <= head_pc;
            bp_update_taken <= head_result.branch.taken;
            if (head_op_type == rob_pkg::type_branch && mispredict) begin
                correct_next_pc <= head_result.branch.taken ? head_next_pc : seq_pc;
            end
        end
    end

    // a flush always comes from a committing branch
    a_flush_on_bp: assert property (@(posedge clk_in) disable iff (rst_in)
        $rose(flush_signal) |-> bp_update_en);
    a_rf_bp_excl: assert property (@(posedge clk_in) disable iff (rst_in)
        !(rf_update_en && bp_update_en));

endmodule

// File: src/rob_top.sv
// reorder buffer top: classifier, entry file and commit unit
`include "rob_cfg.svh"

module rob_top (
    input  logic                    clk_in,
    input  logic                    rst_in,
    input  logic                    rdy_in,
    // dispatcher
    input  logic                    new_entry_en,
    input  logic [`OPCODE_WIDTH-1:0] new_entry_opcode,
    input  logic [`REG_WIDTH-1:0]   new_entry_rd,
    input  logic [`XLEN-1:0]        new_entry_pc,
    input  logic [`XLEN-1:0]        new_entry_next_pc,
    input  logic                    new_entry_predict_taken,
    input  logic                    already_ready,
    input  logic [`XLEN-1:0]        ready_data,
    // completion buses
    input  logic                    cdb_rs_en,
    input  logic [`ROB_WIDTH-1:0]   cdb_rs_index,
    input  logic [`XLEN-1:0]        cdb_rs_data,
    input  logic                    cdb_lsb_en,
    input  logic [`ROB_WIDTH-1:0]   cdb_lsb_index,
    input  logic [`XLEN-1:0]        cdb_lsb_data,
    // operand lookup
    input  logic [`ROB_WIDTH:0]     query_j_index,
    output logic                    query_j_ready,
    output logic [`XLEN-1:0]        query_j_data,
    input  logic [`ROB_WIDTH:0]     query_k_index,
    output logic                    query_k_ready,
    output logic [`XLEN-1:0]        query_k_data,
    // commit side
    output logic                    rf_update_en,
    output logic [`REG_WIDTH-1:0]   rf_update_reg,
    output logic [`ROB_WIDTH-1:0]   rf_update_index,
    output logic [`XLEN-1:0]        rf_update_data,
    output logic                    jalr_feedback_en,
    output logic [`XLEN-1:0]        jalr_feedback_target,
    output logic [`XLEN-1:0]        correct_next_pc,
    output logic                    bp_update_en,
    output logic [`XLEN-1:0]        bp_update_pc,
    output logic                    bp_update_taken,
    output logic                    flush_signal,
    output logic [`ROB_WIDTH-1:0]   head_index,
    output logic [`ROB_WIDTH-1:0]   tail_index,
    output logic                    full
);

    rob_pkg::op_type_t    alloc_op_type;
    logic                 alloc_en;
    logic                 retire_en;
    logic                 flush_clear;
    logic                 head_ready;
    rob_pkg::op_type_t    head_op_type;
    logic [`REG_WIDTH-1:0] head_rd;
    logic [`XLEN-1:0]     head_pc;
    logic [`XLEN-1:0]     head_next_pc;
    logic                 head_predict_taken;
    rob_pkg::rob_result_u head_result;

    // no allocation in either flush cycle, full is checked in the entry file
    assign alloc_en = new_entry_en && !flush_signal;

    rob_op_classify u_classify (
        .opcode  (rob_pkg::opcode_t'(new_entry_opcode)),
        .op_type (alloc_op_type)
    );

    rob_entry_file u_entries (
        .clk_in, .rst_in, .rdy_in,
        .alloc_en, .alloc_op_type,
        .alloc_rd (new_entry_rd), .alloc_pc (new_entry_pc),
        .alloc_next_pc (new_entry_next_pc),
        .alloc_predict_taken (new_entry_predict_taken),
        .alloc_ready (already_ready), .alloc_data (ready_data),
        .cdb_rs_en, .cdb_rs_index, .cdb_rs_data,
        .cdb_lsb_en, .cdb_lsb_index, .cdb_lsb_data,
        .query_j_index, .query_k_index, .retire_en, .flush_clear,
        .query_j_ready, .query_j_data, .query_k_ready, .query_k_data,
        .head_ready, .head_op_type, .head_rd, .head_pc, .head_next_pc,
        .head_predict_taken, .head_result, .head_index, .tail_index, .full
    );

    rob_commit u_commit (
        .clk_in, .rst_in, .rdy_in,
        .head_ready, .head_op_type, .head_rd, .head_pc, .head_next_pc,
        .head_predict_taken, .head_result, .head_index,
        .retire_en, .flush_clear,
        .rf_update_en, .rf_update_reg, .rf_update_index, .rf_update_data,
        .jalr_feedback_en, .jalr_feedback_target, .correct_next_pc,
        .bp_update_en, .bp_update_pc, .bp_update_taken, .flush_signal
    );

endmodule

// File: test/rob_tb.sv
// table-driven reorder buffer testbench covering allocation, completion, commit, flush and full
`include "rob_cfg.svh"

module rob_tb;

    // one dispatched instruction and its final result
    typedef struct packed {
        logic [`OPCODE_WIDTH-1:0] opcode;
        logic [`REG_WIDTH-1:0]    rd;
        logic [`XLEN-1:0]         pc;
        logic [`XLEN-1:0]         next_pc;
        logic                     predict;
        logic                     pre_ready;
        logic [`XLEN-1:0]         result;
    } row_t;

    // one observed commit cycle
    typedef struct packed {
        logic                   rf;
        logic                   jalr;
        logic                   bp;
        logic                   flush;
        logic [`ROB_WIDTH-1:0]  idx;
        logic [`REG_WIDTH-1:0]  rd;
        logic [`XLEN-1:0]       data;
        logic [`XLEN-1:0]       target;
        logic [`XLEN-1:0]       pc;
        logic                   taken;
        logic [`XLEN-1:0]       cnpc;
    } evt_t;

    localparam int K_REG = 0;
    localparam int K_BR = 1;
    localparam int K_JALR = 2;
    localparam int K_ST = 3;

    // reserved query index with no dependency
    localparam logic [`ROB_WIDTH:0] NO_DEP = (`ROB_WIDTH + 1)'(`ROB_SIZE);

    // opcode, rd, pc, next_pc, predicted taken, already ready, result
    localparam row_t ROWS [12] = '{
        '{rob_pkg::op_add, 5'd1, 32'h100, 32'h104, 1'b0, 1'b1, 32'h1111_0001},
        '{rob_pkg::op_lui, 5'd2, 32'h104, 32'h108, 1'b0, 1'b1, 32'h2222_0000},
        '{rob_pkg::op_lw, 5'd3, 32'h108, 32'h10c, 1'b0, 1'b1, 32'hdead_beef},
        '{rob_pkg::op_addi, 5'd4, 32'h10c, 32'h110, 1'b0, 1'b1, 32'h0000_0042},
        '{rob_pkg::op_sub, 5'd5, 32'h110, 32'h114, 1'b0, 1'b0, 32'h5555_aaaa},
        '{rob_pkg::op_lbu, 5'd6, 32'h114, 32'h118, 1'b0, 1'b0, 32'h0000_00ff},
        '{rob_pkg::op_xori, 5'd7, 32'h118, 32'h11c, 1'b0, 1'b0, 32'h7777_0007},
        '{rob_pkg::op_jalr, 5'd1, 32'h11c, 32'h200, 1'b0, 1'b0, 32'h0000_0400},
        '{rob_pkg::op_beq, 5'd0, 32'h120, 32'h180, 1'b1, 1'b0, 32'h0000_0001},
        '{rob_pkg::op_bne, 5'd0, 32'h124, 32'h1c0, 1'b0, 1'b0, 32'h0000_0001},
        '{rob_pkg::op_sw, 5'd0, 32'h128, 32'h12c, 1'b0, 1'b0, 32'h0000_0000},
        '{rob_pkg::op_blt, 5'd0, 32'h12c, 32'h300, 1'b1, 1'b0, 32'h0000_0000}
    };

    logic clk_in, rst_in, rdy_in;
    logic new_entry_en, new_entry_predict_taken, already_ready;
    logic [`OPCODE_WIDTH-1:0] new_entry_opcode;
    logic [`REG_WIDTH-1:0] new_entry_rd, rf_update_reg;
    logic [`XLEN-1:0] new_entry_pc, new_entry_next_pc, ready_data;
    logic cdb_rs_en, cdb_lsb_en;
    logic [`ROB_WIDTH-1:0] cdb_rs_index, cdb_lsb_index, rf_update_index;
    logic [`XLEN-1:0] cdb_rs_data, cdb_lsb_data, query_j_data, query_k_data;
    logic [`ROB_WIDTH:0] query_j_index, query_k_index;
    logic query_j_ready, query_k_ready, rf_update_en, jalr_feedback_en;
    logic [`XLEN-1:0] rf_update_data, jalr_feedback_target, correct_next_pc, bp_update_pc;
    logic bp_update_en, bp_update_taken, flush_signal, full;
    logic [`ROB_WIDTH-1:0] head_index, tail_index;

    evt_t log_q [$];
    int flush_cycles;
    logic [`ROB_WIDTH-1:0] tail_m;
    logic [`ROB_WIDTH-1:0] ix [5];
    int ord [5];
    int j, tmp;
    int br_rows [2] = '{9, 11};

    rob_top uut (.*);

    initial begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    // commit outputs sampled mid-cycle
    always @(negedge clk_in) begin
        if (flush_signal) flush_cycles++;
        if (rf_update_en || bp_update_en) begin
            log_q.push_back('{rf_update_en, jalr_feedback_en, bp_update_en, flush_signal,
                rf_update_index, rf_update_reg, rf_update_data, jalr_feedback_target,
                bp_update_pc, bp_update_taken, correct_next_pc});
        end
    end

    task automatic stop_run();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_word(input string name, input logic [`XLEN-1:0] got,
                              input logic [`XLEN-1:0] exp);
        assert (got === exp) else begin
            $display("ERROR %s expected %h got %h", name, exp, got);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("ERROR %s expected %h got %h", name, exp, got);
            stop_run();
        end
    endtask

    // inputs change one unit after the edge
    task automatic step();
        @(posedge clk_in);
        #1;
    endtask

    // op class from the dispatcher numbering
    function automatic int row_kind(input logic [`OPCODE_WIDTH-1:0] opc);
        if (opc == rob_pkg::op_jalr) return K_JALR;
        if (opc >= rob_pkg::op_beq && opc <= rob_pkg::op_bgeu) return K_BR;
        if (opc >= rob_pkg::op_sb && opc <= rob_pkg::op_sw) return K_ST;
        return K_REG;
    endfunction

    task automatic drive_row(input int r);
        new_entry_opcode = ROWS[r].opcode;
        new_entry_rd = ROWS[r].rd;
        new_entry_pc = ROWS[r].pc;
        new_entry_next_pc = ROWS[r].next_pc;
        new_entry_predict_taken = ROWS[r].predict;
        already_ready = ROWS[r].pre_ready;
        ready_data = ROWS[r].pre_ready ? ROWS[r].result : '0;
    endtask

    // one allocation with the tail checked against the model first
    task automatic issue(input int r);
        check_word("tail_index", 32'(tail_index), 32'(tail_m));
        drive_row(r);
        new_entry_en = 1'b1;
        step();
        new_entry_en = 1'b0;
        tail_m = tail_m + 1'b1;
    endtask

    // bus write on a random bus and the operand lookup one cycle later
    task automatic complete(input logic [`ROB_WIDTH-1:0] idx, input logic [`XLEN-1:0] data);
        logic on_lsb;
        on_lsb = ($urandom_range(1) == 1);
        // port k answers lsb writes and port j answers rs writes
        if (on_lsb) begin
            cdb_lsb_en = 1'b1;
            cdb_lsb_index = idx;
            cdb_lsb_data = data;
            query_j_index = NO_DEP;
            query_k_index = {1'b0, idx};
        end else begin
            cdb_rs_en = 1'b1;
            cdb_rs_index = idx;
            cdb_rs_data = data;
            query_j_index = {1'b0, idx};
            query_k_index = NO_DEP;
        end
        step();
        cdb_rs_en = 1'b0;
        cdb_lsb_en = 1'b0;
        if (on_lsb) begin
            check_bit("query_k_ready", query_k_ready, 1'b1);
            check_word("query_k_data", query_k_data, data);
            check_bit("query_j_ready", query_j_ready, 1'b0);
            check_word("query_j_data", query_j_data, '0);
        end else begin
            check_bit("query_j_ready", query_j_ready, 1'b1);
            check_word("query_j_data", query_j_data, data);
            check_bit("query_k_ready", query_k_ready, 1'b0);
            check_word("query_k_data", query_k_data, '0);
        end
    endtask

    task automatic wait_log(input int n);
        int waited;
        waited = 0;
        while (log_q.size() < n && waited < 40) begin
            step();
            waited++;
        end
        assert (log_q.size() >= n) else begin
            $display("timed out waiting for %0d commit pulses, saw %0d", n, log_q.size());
            stop_run();
        end
    endtask

    // oldest logged commit against the row it should belong to
    task automatic check_commit(input int r, input logic [`ROB_WIDTH-1:0] idx);
        evt_t e;
        row_t w;
        int kind;
        logic mis;
        e = log_q.pop_front();
        w = ROWS[r];
        kind = row_kind(w.opcode);
        mis = w.result[0] != w.predict;
        check_bit("rf_update_en", e.rf, kind == K_REG || kind == K_JALR);
        check_bit("jalr_feedback_en", e.jalr, kind == K_JALR);
        check_bit("bp_update_en", e.bp, kind == K_BR);
        if (kind == K_BR) begin
            check_word("bp_update_pc", e.pc, w.pc);
            check_bit("bp_update_taken", e.taken, w.result[0]);
            check_bit("flush_signal", e.flush, mis);
            if (mis) check_word("correct_next_pc", e.cnpc, w.result[0] ? w.next_pc : w.pc + 4);
        end else begin
            check_word("rf_update_index", 32'(e.idx), 32'(idx));
            check_word("rf_update_reg", 32'(e.rd), 32'(w.rd));
            check_word("rf_update_data", e.data, kind == K_JALR ? w.pc + 4 : w.result);
            if (kind == K_JALR) check_word("jalr_feedback_target", e.target, w.result);
        end
    endtask

    initial begin
        void'($urandom(32'hd714));
        rst_in = 1'b1;
        rdy_in = 1'b1;
        new_entry_en = 1'b0;
        drive_row(0);
        cdb_rs_en = 1'b0;
        cdb_rs_index = '0;
        cdb_rs_data = '0;
        cdb_lsb_en = 1'b0;
        cdb_lsb_index = '0;
        cdb_lsb_data = '0;
        query_j_index = NO_DEP;
        query_k_index = NO_DEP;
        flush_cycles = 0;
        tail_m = '0;
        repeat (4) @(posedge clk_in);
        #1;
        rst_in = 1'b0;
        check_bit("rf_update_en", rf_update_en, 1'b0);
        check_bit("jalr_feedback_en", jalr_feedback_en, 1'b0);
        check_bit("bp_update_en", bp_update_en, 1'b0);
        check_bit("flush_signal", flush_signal, 1'b0);
        check_bit("full", full, 1'b0);
        check_word("head_index", 32'(head_index), 0);
        check_word("tail_index", 32'(tail_index), 0);

        // ready at dispatch so the pulse comes two edges after the drive
        for (int r = 0; r < 4; r++) begin
            issue(r);
            check_bit("rf_update_en", rf_update_en, 1'b0);
            step();
            check_bit("rf_update_en", rf_update_en, 1'b1);
            wait_log(1);
            check_commit(r, tail_m - 1'b1);
        end

        // registers, jalr and a good branch finished in shuffled order
        for (int k = 0; k < 5; k++) begin
            ix[k] = tail_m;
            ord[k] = k;
            issue(4 + k);
        end
        for (int i = 4; i > 0; i--) begin
            j = int'($urandom % (i + 1));
            tmp = ord[i];
            ord[i] = ord[j];
            ord[j] = tmp;
        end
        for (int k = 0; k < 5; k++) complete(ix[ord[k]], ROWS[4 + ord[k]].result);
        wait_log(5);
        for (int k = 0; k < 5; k++) check_commit(4 + k, ix[k]);
        check_word("flush cycles", flush_cycles, 0);

        // taken and not-taken mispredicts with ready work behind
        foreach (br_rows[b]) begin
            flush_cycles = 0;
            ix[0] = tail_m;
            issue(br_rows[b]);
            issue(0);
            issue(1);
            complete(ix[0], ROWS[br_rows[b]].result);
            wait_log(1);
            check_commit(br_rows[b], ix[0]);
            repeat (4) step();
            check_word("commits after flush", log_q.size(), 0);
            check_word("flush cycles", flush_cycles, 2);
            check_word("head_index", 32'(head_index), 0);
            check_word("tail_index", 32'(tail_index), 0);
            tail_m = '0;
        end

        // store at head with seven more behind it
        issue(10);
        for (int r = 0; r < 7; r++) issue(r);
        check_bit("full", full, 1'b1);
        drive_row(0);
        new_entry_en = 1'b1;
        step();
        new_entry_en = 1'b0;
        check_word("tail_index", 32'(tail_index), 32'(tail_m));
        complete(3'd0, ROWS[10].result);
        // stall right before the store could retire
        rdy_in = 1'b0;
        repeat (5) step();
        check_word("head_index", 32'(head_index), 0);
        check_bit("full", full, 1'b1);
        check_word("commits while stalled", log_q.size(), 0);
        rdy_in = 1'b1;
        step();
        check_word("head_index", 32'(head_index), 1);
        check_bit("full", full, 1'b0);
        for (int r = 4; r < 7; r++) complete(3'(r + 1), ROWS[r].result);
        wait_log(7);
        for (int r = 0; r < 7; r++) check_commit(r, 3'(r + 1));
        step();
        check_word("extra commits", log_q.size(), 0);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: build.f
+incdir+include
src/rob_pkg.sv
src/rob_op_classify.sv
src/rob_entry_file.sv
src/rob_commit.sv
src/rob_top.sv
test/rob_tb.sv

// File: Makefile
# Verilator build and run of the reorder buffer testbench
VERILATOR ?= verilator
TOP       ?= rob_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) include/rob_cfg.svh
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
